// ==== src/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  localparam int XLEN_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = 5;

  typedef logic [XLEN_W-1:0]     xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes, RV32I base
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  typedef enum logic [3:0] {
    OP_NONE,   // Unsupported, done report only
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU,
    OP_LUI,
    OP_AUIPC
  } alu_op_e;

  typedef enum logic [1:0] {
    IMM_NONE,
    IMM_I,
    IMM_SH,  // Shift amount in the rs2 field
    IMM_U
  } imm_sel_e;

  // One instruction word, two decodes
  // I-type immediate sits in funct7/rs2 of the r view
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [19:0] imm20;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } u;
  } rv_inst_u;

endpackage

`default_nettype wire

// ==== src/alu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_decoder
  import alu_pkg::*;
(
  input  rv_inst_u  i_inst,
  output alu_op_e   o_op,
  output imm_sel_e  o_imm_sel,
  output reg_addr_t o_rs1,
  output reg_addr_t o_rs2,
  output reg_addr_t o_rd,
  output logic      o_rs1_used,
  output logic      o_rs2_used,
  output logic      o_wr_en
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_inst.r.opcode;
  assign funct3 = i_inst.r.funct3;
  assign funct7 = i_inst.r.funct7;

  assign o_rs1 = i_inst.r.rs1;
  assign o_rs2 = i_inst.r.rs2;

  always_comb begin
    o_op       = OP_NONE;
    o_imm_sel  = IMM_NONE;
    o_rs1_used = 1'b0;
    o_rs2_used = 1'b0;
    o_rd       = i_inst.r.rd;
    case (opcode)
      OPC_LUI: begin
        o_op      = OP_LUI;
        o_imm_sel = IMM_U;
      end
      OPC_AUIPC: begin
        o_op      = OP_AUIPC;
        o_imm_sel = IMM_U;
      end
      OPC_OP_IMM: begin
        o_rs1_used = 1'b1;
        o_imm_sel  = IMM_I;
        case (funct3)
          3'b000: o_op = OP_ADD;
          3'b010: o_op = OP_SLT;
          3'b011: o_op = OP_SLTU;
          3'b100: o_op = OP_XOR;
          3'b110: o_op = OP_OR;
          3'b111: o_op = OP_AND;
          3'b001: begin
            o_imm_sel = IMM_SH;
            if (funct7 == 7'b0000000) o_op = OP_SLL;
          end
          default: begin  // 3'b101, SRLI or SRAI
            o_imm_sel = IMM_SH;
            if (funct7 == 7'b0000000) o_op = OP_SRL;
            else if (funct7 == 7'b0100000) o_op = OP_SRA;
          end
        endcase
      end
      OPC_OP: begin
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  o_op = OP_ADD;
            3'b001:  o_op = OP_SLL;
            3'b010:  o_op = OP_SLT;
            3'b011:  o_op = OP_SLTU;
            3'b100:  o_op = OP_XOR;
            3'b101:  o_op = OP_SRL;
            3'b110:  o_op = OP_OR;
            default: o_op = OP_AND;
          endcase
        end else if (funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) o_op = OP_SUB;
          else if (funct3 == 3'b101) o_op = OP_SRA;
        end
      end
      default: ;
    endcase
  end

  // No writeback to x0 or for unknown encodings
  assign o_wr_en = (o_op != OP_NONE) && (o_rd != '0);

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import alu_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  reg_addr_t i_rd_addr_a,
  input  reg_addr_t i_rd_addr_b,
  output xlen_t     o_rd_data_a,
  output xlen_t     o_rd_data_b,
  input  logic      i_wr_en,
  input  reg_addr_t i_wr_addr,
  input  xlen_t     i_wr_data
);

  localparam int NUM_REGS = 2**REG_ADDR_W;

  xlen_t regs [1:NUM_REGS-1];  // x0 is not stored

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_en && (i_wr_addr != '0)) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  // Combinational read, x0 reads zero
  assign o_rd_data_a = (i_rd_addr_a == '0) ? '0 : regs[i_rd_addr_a];
  assign o_rd_data_b = (i_rd_addr_b == '0) ? '0 : regs[i_rd_addr_b];

endmodule

`default_nettype wire

// ==== src/operand_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_stage
  import alu_pkg::*;
#(
  parameter int TAG_W = 6
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_valid,
  input  rv_inst_u         i_inst,
  input  xlen_t            i_pc,
  input  logic [TAG_W-1:0] i_tag,
  input  alu_op_e          i_op,
  input  imm_sel_e         i_imm_sel,
  input  reg_addr_t        i_rs1,
  input  reg_addr_t        i_rs2,
  input  reg_addr_t        i_rd,
  input  logic             i_rs1_used,
  input  logic             i_rs2_used,
  input  logic             i_wr_en,
  output reg_addr_t        o_rf_addr_a,
  output reg_addr_t        o_rf_addr_b,
  input  xlen_t            i_rf_data_a,
  input  xlen_t            i_rf_data_b,
  input  logic             i_wb_valid,
  input  reg_addr_t        i_wb_rd,
  input  xlen_t            i_wb_data,
  output logic             o_valid,
  output alu_op_e          o_op,
  output reg_addr_t        o_rd,
  output logic             o_wr_en,
  output logic [TAG_W-1:0] o_tag,
  output xlen_t            o_pc,
  output xlen_t            o_imm_u,
  output reg_addr_t        o_rs1,
  output reg_addr_t        o_rs2,
  output logic             o_rs2_is_reg,
  output xlen_t            o_opnd_a,
  output xlen_t            o_opnd_b
);

  logic             r_ex1_valid;
  logic             r_ex1_wr_en;
  rv_inst_u         r_ex1_inst;
  xlen_t            r_ex1_pc;
  logic [TAG_W-1:0] r_ex1_tag;
  alu_op_e          r_ex1_op;
  imm_sel_e         r_ex1_imm_sel;
  reg_addr_t        r_ex1_rs1;
  reg_addr_t        r_ex1_rs2;
  reg_addr_t        r_ex1_rd;
  logic             r_ex1_rs2_used;

  logic  fwd_a;
  logic  fwd_b;
  xlen_t ex1_rs1_data;
  xlen_t ex1_rs2_data;
  xlen_t ex1_imm_i;
  xlen_t ex1_opnd_b;

  // --------------------
  // EX0 -> EX1
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex1_wr_en <= 1'b0;
    end else begin
      r_ex1_valid <= i_valid;
      r_ex1_wr_en <= i_valid && i_wr_en;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_inst     <= i_inst;
    r_ex1_pc       <= i_pc;
    r_ex1_tag      <= i_tag;
    r_ex1_op       <= i_op;
    r_ex1_imm_sel  <= i_imm_sel;
    r_ex1_rs1      <= i_rs1_used ? i_rs1 : '0;  // Unused source acts as x0
    r_ex1_rs2      <= i_rs2_used ? i_rs2 : '0;
    r_ex1_rd       <= i_rd;
    r_ex1_rs2_used <= i_rs2_used;
  end

  // --------------------
  // EX1 read and forward
  assign o_rf_addr_a = r_ex1_rs1;
  assign o_rf_addr_b = r_ex1_rs2;

  // Producer two ahead is on the writeback bus now
  assign fwd_a = i_wb_valid && (r_ex1_rs1 != '0) && (r_ex1_rs1 == i_wb_rd);
  assign fwd_b = i_wb_valid && (r_ex1_rs2 != '0) && (r_ex1_rs2 == i_wb_rd);

  assign ex1_rs1_data = fwd_a ? i_wb_data : i_rf_data_a;
  assign ex1_rs2_data = fwd_b ? i_wb_data : i_rf_data_b;

  assign ex1_imm_i = {{(XLEN_W-12){r_ex1_inst.r.funct7[6]}}, r_ex1_inst.r.funct7, r_ex1_inst.r.rs2};

  always_comb begin
    case (r_ex1_imm_sel)
      IMM_I:   ex1_opnd_b = ex1_imm_i;
      IMM_SH:  ex1_opnd_b = {{(XLEN_W-SHAMT_W){1'b0}}, r_ex1_inst.r.rs2[SHAMT_W-1:0]};
      default: ex1_opnd_b = ex1_rs2_data;
    endcase
  end

  // --------------------
  // EX1 -> EX2
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid <= 1'b0;
      o_wr_en <= 1'b0;
    end else begin
      o_valid <= r_ex1_valid;
      o_wr_en <= r_ex1_wr_en;
    end
  end

  always_ff @(posedge i_clk) begin
    o_op         <= r_ex1_op;
    o_rd         <= r_ex1_rd;
    o_tag        <= r_ex1_tag;
    o_pc         <= r_ex1_pc;
    o_imm_u      <= {r_ex1_inst.u.imm20, 12'h000};
    o_rs1        <= r_ex1_rs1;
    o_rs2        <= r_ex1_rs2;
    o_rs2_is_reg <= r_ex1_rs2_used;
    o_opnd_a     <= ex1_rs1_data;
    o_opnd_b     <= ex1_opnd_b;
  end

endmodule

`default_nettype wire

// ==== src/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_execute
  import alu_pkg::*;
#(
  parameter int TAG_W = 6
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_valid,
  input  alu_op_e          i_op,
  input  reg_addr_t        i_rd,
  input  logic             i_wr_en,
  input  logic [TAG_W-1:0] i_tag,
  input  xlen_t            i_pc,
  input  xlen_t            i_imm_u,
  input  reg_addr_t        i_rs1,
  input  reg_addr_t        i_rs2,
  input  logic             i_rs2_is_reg,
  input  xlen_t            i_opnd_a,
  input  xlen_t            i_opnd_b,
  output logic             o_wb_valid,
  output reg_addr_t        o_wb_rd,
  output xlen_t            o_wb_data,
  output logic             o_done_valid,
  output logic [TAG_W-1:0] o_done_tag
);

  logic               fwd_a;
  logic               fwd_b;
  xlen_t              opnd_a;
  xlen_t              opnd_b;
  xlen_t              result;
  logic [SHAMT_W-1:0] shamt;

  // --------------------
  // EX2 forward
  // Producer one ahead is sitting in EX3
  assign fwd_a = o_wb_valid && (i_rs1 != '0) && (i_rs1 == o_wb_rd);
  assign fwd_b = o_wb_valid && i_rs2_is_reg && (i_rs2 != '0) && (i_rs2 == o_wb_rd);

  assign opnd_a = fwd_a ? o_wb_data : i_opnd_a;
  assign opnd_b = fwd_b ? o_wb_data : i_opnd_b;

  assign shamt = opnd_b[SHAMT_W-1:0];

  // --------------------
  // EX2 compute
  always_comb begin
    case (i_op)
      OP_ADD:   result = opnd_a + opnd_b;
      OP_SUB:   result = opnd_a - opnd_b;
      OP_AND:   result = opnd_a & opnd_b;
      OP_OR:    result = opnd_a | opnd_b;
      OP_XOR:   result = opnd_a ^ opnd_b;
      OP_SLL:   result = opnd_a << shamt;
      OP_SRL:   result = opnd_a >> shamt;
      OP_SRA:   result = $signed(opnd_a) >>> shamt;
      OP_SLT:   result = {{(XLEN_W-1){1'b0}}, $signed(opnd_a) < $signed(opnd_b)};
      OP_SLTU:  result = {{(XLEN_W-1){1'b0}}, opnd_a < opnd_b};
      OP_LUI:   result = i_imm_u;
      OP_AUIPC: result = i_pc + i_imm_u;
      default:  result = '0;
    endcase
  end

  // --------------------
  // EX3 writeback and done
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_wb_valid   <= 1'b0;
      o_done_valid <= 1'b0;
    end else begin
      o_wb_valid   <= i_valid && i_wr_en;
      o_done_valid <= i_valid;
    end
  end

  // Bus holds the last report between instructions
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_wb_rd    <= '0;
      o_wb_data  <= '0;
      o_done_tag <= '0;
    end else if (i_valid) begin
      o_wb_rd    <= i_rd;
      o_wb_data  <= result;
      o_done_tag <= i_tag;
    end
  end

endmodule

`default_nettype wire

// ==== src/alu_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_top
  import alu_pkg::*;
#(
  parameter int TAG_W = 6
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_issue_valid,
  input  logic [31:0]      i_issue_inst,
  input  xlen_t            i_issue_pc,
  input  logic [TAG_W-1:0] i_issue_tag,
  output logic             o_wb_valid,
  output reg_addr_t        o_wb_rd,
  output xlen_t            o_wb_data,
  output logic             o_done_valid,
  output logic [TAG_W-1:0] o_done_tag
);

  // EX0 decode
  alu_op_e   dec_op;
  imm_sel_e  dec_imm_sel;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  reg_addr_t dec_rd;
  logic      dec_rs1_used;
  logic      dec_rs2_used;
  logic      dec_wr_en;

  reg_addr_t rf_addr_a;
  reg_addr_t rf_addr_b;
  xlen_t     rf_data_a;
  xlen_t     rf_data_b;

  // EX2 stage
  logic             ex2_valid;
  alu_op_e          ex2_op;
  reg_addr_t        ex2_rd;
  logic             ex2_wr_en;
  logic [TAG_W-1:0] ex2_tag;
  xlen_t            ex2_pc;
  xlen_t            ex2_imm_u;
  reg_addr_t        ex2_rs1;
  reg_addr_t        ex2_rs2;
  logic             ex2_rs2_is_reg;
  xlen_t            ex2_opnd_a;
  xlen_t            ex2_opnd_b;

  alu_decoder u_decoder (
    .i_inst     (i_issue_inst),
    .o_op       (dec_op),
    .o_imm_sel  (dec_imm_sel),
    .o_rs1      (dec_rs1),
    .o_rs2      (dec_rs2),
    .o_rd       (dec_rd),
    .o_rs1_used (dec_rs1_used),
    .o_rs2_used (dec_rs2_used),
    .o_wr_en    (dec_wr_en)
  );

  reg_file u_reg_file (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_rd_addr_a (rf_addr_a),
    .i_rd_addr_b (rf_addr_b),
    .o_rd_data_a (rf_data_a),
    .o_rd_data_b (rf_data_b),
    .i_wr_en     (o_wb_valid),
    .i_wr_addr   (o_wb_rd),
    .i_wr_data   (o_wb_data)
  );

  operand_stage #(
    .TAG_W (TAG_W)
  ) u_operand_stage (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_valid      (i_issue_valid),
    .i_inst       (i_issue_inst),
    .i_pc         (i_issue_pc),
    .i_tag        (i_issue_tag),
    .i_op         (dec_op),
    .i_imm_sel    (dec_imm_sel),
    .i_rs1        (dec_rs1),
    .i_rs2        (dec_rs2),
    .i_rd         (dec_rd),
    .i_rs1_used   (dec_rs1_used),
    .i_rs2_used   (dec_rs2_used),
    .i_wr_en      (dec_wr_en),
    .o_rf_addr_a  (rf_addr_a),
    .o_rf_addr_b  (rf_addr_b),
    .i_rf_data_a  (rf_data_a),
    .i_rf_data_b  (rf_data_b),
    .i_wb_valid   (o_wb_valid),
    .i_wb_rd      (o_wb_rd),
    .i_wb_data    (o_wb_data),
    .o_valid      (ex2_valid),
    .o_op         (ex2_op),
    .o_rd         (ex2_rd),
    .o_wr_en      (ex2_wr_en),
    .o_tag        (ex2_tag),
    .o_pc         (ex2_pc),
    .o_imm_u      (ex2_imm_u),
    .o_rs1        (ex2_rs1),
    .o_rs2        (ex2_rs2),
    .o_rs2_is_reg (ex2_rs2_is_reg),
    .o_opnd_a     (ex2_opnd_a),
    .o_opnd_b     (ex2_opnd_b)
  );

  alu_execute #(
    .TAG_W (TAG_W)
  ) u_execute (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_valid      (ex2_valid),
    .i_op         (ex2_op),
    .i_rd         (ex2_rd),
    .i_wr_en      (ex2_wr_en),
    .i_tag        (ex2_tag),
    .i_pc         (ex2_pc),
    .i_imm_u      (ex2_imm_u),
    .i_rs1        (ex2_rs1),
    .i_rs2        (ex2_rs2),
    .i_rs2_is_reg (ex2_rs2_is_reg),
    .i_opnd_a     (ex2_opnd_a),
    .i_opnd_b     (ex2_opnd_b),
    .o_wb_valid   (o_wb_valid),
    .o_wb_rd      (o_wb_rd),
    .o_wb_data    (o_wb_data),
    .o_done_valid (o_done_valid),
    .o_done_tag   (o_done_tag)
  );

endmodule

`default_nettype wire

// ==== testbench/alu_pipe_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_checker
  import alu_pkg::*;
#(
  parameter int TAG_W = 6
) (
  input logic             i_clk,
  input logic             i_reset_n,
  input logic             i_issue_valid,
  input logic             o_wb_valid,
  input reg_addr_t        o_wb_rd,
  input xlen_t            o_wb_data,
  input logic             o_done_valid,
  input logic [TAG_W-1:0] o_done_tag
);

  a_wb_with_done: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) o_wb_valid |-> o_done_valid
  ) else $error("writeback seen without a done report");

  a_wb_rd_nonzero: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) o_wb_valid |-> (o_wb_rd != '0)
  ) else $error("writeback targets x0");

  // Fixed latency, no stalls
  a_done_latency: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) i_issue_valid |-> ##3 o_done_valid
  ) else $error("issue not followed by a done report three cycles later");

  a_no_unknown: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      !$isunknown({o_wb_valid, o_wb_rd, o_wb_data, o_done_valid, o_done_tag})
  ) else $error("unknown value on an output");

endmodule

bind alu_pipe_top alu_pipe_checker #(
  .TAG_W (TAG_W)
) u_checker (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_issue_valid (i_issue_valid),
  .o_wb_valid    (o_wb_valid),
  .o_wb_rd       (o_wb_rd),
  .o_wb_data     (o_wb_data),
  .o_done_valid  (o_done_valid),
  .o_done_tag    (o_done_tag)
);

`default_nettype wire

// ==== testbench/alu_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_tb;

  localparam int TAG_W          = 6;
  localparam int NUM_INSTS      = 400;
  localparam int RESET_CYCLES   = 5;
  localparam int GAP_BUDGET     = 30;  // Idle cycles spread over the second half
  localparam int TIMEOUT_CYCLES = NUM_INSTS + 3 + RESET_CYCLES + 50;

  logic             clk;
  logic             reset_n;
  logic             issue_valid;
  logic [31:0]      issue_inst;
  logic [31:0]      issue_pc;
  logic [TAG_W-1:0] issue_tag;
  logic             wb_valid;
  logic [4:0]       wb_rd;
  logic [31:0]      wb_data;
  logic             done_valid;
  logic [TAG_W-1:0] done_tag;

  logic [31:0]      model_regs [32];
  logic [TAG_W-1:0] tag_q [$];
  logic             wb_q [$];
  logic [4:0]       rd_q [$];
  logic [31:0]      data_q [$];
  int               edge_q [$];

  logic             ref_wb;
  logic [4:0]       ref_rd;
  logic [31:0]      ref_data;
  logic [TAG_W-1:0] exp_tag;
  logic             exp_wb;
  logic [4:0]       exp_rd;
  logic [31:0]      exp_data;
  int               exp_edge;

  int cycle_cnt       = 0;
  int mismatch_errors = 0;
  int other_errors    = 0;
  int gap;
  int gap_used;

  alu_pipe_top #(
    .TAG_W (TAG_W)
  ) i_dut (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_issue_valid (issue_valid),
    .i_issue_inst  (issue_inst),
    .i_issue_pc    (issue_pc),
    .i_issue_tag   (issue_tag),
    .o_wb_valid    (wb_valid),
    .o_wb_rd       (wb_rd),
    .o_wb_data     (wb_data),
    .o_done_valid  (done_valid),
    .o_done_tag    (done_tag)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // --------------------
  // Reference model, RV32I semantics
  function automatic void ref_model(
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic [31:0] regs [32],
    output logic        wb,
    output logic [4:0]  rd,
    output logic [31:0] data
  );
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        kept;
    a    = regs[inst[19:15]];
    b    = regs[inst[24:20]];
    imm  = {{20{inst[31]}}, inst[31:20]};
    f3   = inst[14:12];
    f7   = inst[31:25];
    rd   = inst[11:7];
    kept = 1'b1;
    data = '0;
    case (inst[6:0])
      7'h37: data = {inst[31:12], 12'h000};       // LUI
      7'h17: data = pc + {inst[31:12], 12'h000};  // AUIPC
      7'h13: begin
        case (f3)
          3'd0: data = a + imm;
          3'd2: data = {31'd0, $signed(a) < $signed(imm)};
          3'd3: data = {31'd0, a < imm};
          3'd4: data = a ^ imm;
          3'd6: data = a | imm;
          3'd7: data = a & imm;
          3'd1: begin
            if (f7 == 7'h00) data = a << inst[24:20];
            else kept = 1'b0;
          end
          default: begin
            if (f7 == 7'h00) data = a >> inst[24:20];
            else if (f7 == 7'h20) data = $signed(a) >>> inst[24:20];
            else kept = 1'b0;
          end
        endcase
      end
      7'h33: begin
        if (f7 == 7'h00) begin
          case (f3)
            3'd0: data = a + b;
            3'd1: data = a << b[4:0];
            3'd2: data = {31'd0, $signed(a) < $signed(b)};
            3'd3: data = {31'd0, a < b};
            3'd4: data = a ^ b;
            3'd5: data = a >> b[4:0];
            3'd6: data = a | b;
            default: data = a & b;
          endcase
        end else if (f7 == 7'h20 && f3 == 3'd0) begin
          data = a - b;
        end else if (f7 == 7'h20 && f3 == 3'd5) begin
          data = $signed(a) >>> b[4:0];
        end else begin
          kept = 1'b0;
        end
      end
      default: kept = 1'b0;
    endcase
    wb = kept && (rd != 5'd0);
  endfunction

  // Small register window keeps dependencies dense
  function automatic logic [31:0] make_inst();
    logic [31:0] rnd;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    int          kind;
    int          pick;
    rnd  = $urandom;
    rd   = 5'($urandom % 8);
    rs1  = 5'($urandom % 8);
    rs2  = 5'($urandom % 8);
    f3   = 3'($urandom);
    imm  = 12'($urandom);
    pick = $urandom % 8;
    f7   = (pick < 4) ? 7'h00 : ((pick < 7) ? 7'h20 : 7'h01);
    if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = f7;  // Shift immediates
    kind = $urandom % 16;
    if (kind == 0) return {rnd[31:12], rd, 7'h37};
    if (kind == 1) return {rnd[31:12], rd, 7'h17};
    if (kind < 8) return {imm, rs1, f3, rd, 7'h13};
    if (kind < 14) return {f7, rs2, rs1, f3, rd, 7'h33};
    case ($urandom % 4)  // Load, store, branch, system
      0: return {rnd[31:12], rd, 7'h03};
      1: return {rnd[31:12], rd, 7'h23};
      2: return {rnd[31:12], rd, 7'h63};
      default: return {rnd[31:12], rd, 7'h73};
    endcase
  endfunction

  task automatic finish_run();
    $display("Error counts: %0d mismatches, %0d other", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  // --------------------
  // Stimulus
  initial begin
    void'($urandom(32'hd768));
    reset_n     = 1'b0;
    issue_valid = 1'b0;
    issue_inst  = '0;
    issue_pc    = '0;
    issue_tag   = '0;
    gap_used    = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    for (int n = 0; n < NUM_INSTS; n++) begin
      if (n >= NUM_INSTS / 2 && gap_used < GAP_BUDGET && ($urandom % 6) == 0) begin
        gap = 1 + $urandom % 3;
        if (gap > GAP_BUDGET - gap_used) gap = GAP_BUDGET - gap_used;
        gap_used += gap;
        issue_valid = 1'b0;
        repeat (gap) @(negedge clk);
      end
      issue_inst = make_inst();
      issue_pc   = $urandom & 32'hffff_fffc;
      ref_model(issue_inst, issue_pc, model_regs, ref_wb, ref_rd, ref_data);
      if (ref_wb) model_regs[ref_rd] = ref_data;  // Program order
      tag_q.push_back(issue_tag);
      wb_q.push_back(ref_wb);
      rd_q.push_back(ref_rd);
      data_q.push_back(ref_data);
      edge_q.push_back(cycle_cnt);  // Issue cycle
      issue_valid = 1'b1;
      @(negedge clk);
      issue_tag = issue_tag + 1'b1;
    end
    issue_valid = 1'b0;
    while (tag_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    finish_run();
  end

  // --------------------
  // Compare at the falling edge, outputs are stable there
  always @(negedge clk) begin
    if (reset_n && done_valid) begin
      if (tag_q.size() == 0) begin
        other_errors++;
        $display("Error at %0t: done report with tag %0h arrived with nothing outstanding",
                 $time, done_tag);
      end else begin
        exp_tag  = tag_q.pop_front();
        exp_wb   = wb_q.pop_front();
        exp_rd   = rd_q.pop_front();
        exp_data = data_q.pop_front();
        exp_edge = edge_q.pop_front();
        assert (done_tag == exp_tag) else begin
          mismatch_errors++;
          $display("MISMATCH at %0t: done tag %0h, expected %0h", $time, done_tag, exp_tag);
        end
        assert (wb_valid == exp_wb) else begin
          mismatch_errors++;
          $display("MISMATCH at %0t: tag %0h writeback flag %0b, expected %0b",
                   $time, exp_tag, wb_valid, exp_wb);
        end
        if (exp_wb) begin
          assert (wb_rd == exp_rd) else begin
            mismatch_errors++;
            $display("MISMATCH at %0t: tag %0h rd %0d, expected %0d",
                     $time, exp_tag, wb_rd, exp_rd);
          end
          assert (wb_data == exp_data) else begin
            mismatch_errors++;
            $display("MISMATCH at %0t: tag %0h data %08h, expected %08h",
                     $time, exp_tag, wb_data, exp_data);
          end
        end
        assert (cycle_cnt == exp_edge + 3) else begin
          mismatch_errors++;
          $display("MISMATCH at %0t: tag %0h done after %0d cycles, expected 3",
                   $time, exp_tag, cycle_cnt - exp_edge);
        end
      end
    end
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) @(posedge clk);
    other_errors++;
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== sim.f ====
src/alu_pkg.sv
src/alu_decoder.sv
src/reg_file.sv
src/operand_stage.sv
src/alu_execute.sv
src/alu_pipe_top.sv
testbench/alu_pipe_checker.sv
testbench/alu_pipe_tb.sv
